// File: src/emesh_pkg.sv
// ##########################################################################
// Shared emesh definitions for the single-link traffic driver
// Packet layout is fixed at 104 bits, ctrlmode is carried but not decoded
// Byte and half-word modes are served as word accesses by the memory
// ##########################################################################
package emesh_pkg;

   // Widths
   localparam int AW        = 32;              // Address width
   localparam int IDW       = 12;              // Coreid width, top of dstaddr
   localparam int MAW       = 12;              // Memory byte address width
   localparam int PW        = 104;             // Packet width
   localparam int MEM_DEPTH = 1 << (MAW - 3);  // 64-bit entries
   localparam int CNT_W     = 16;              // Monitor counter width

   // Data mode codes
   localparam logic [1:0] DM_BYTE   = 2'b00;
   localparam logic [1:0] DM_HALF   = 2'b01;
   localparam logic [1:0] DM_WORD   = 2'b10;
   localparam logic [1:0] DM_DOUBLE = 2'b11;

   // ########################################################################
   // Stimulus sequence
   // ########################################################################
   localparam int              STIM_COUNT     = 16;
   localparam int              STIM_IDX_W     = $clog2(STIM_COUNT);
   localparam logic [AW-1:0]   STIM_BASE      = 32'h0000_0800;  // Window inside target
   localparam logic [31:0]     STIM_DATA_SEED = 32'hC0DE_0000;
   localparam logic [31:0]     STIM_DATA_STEP = 32'h0101_0101;  // Added per packet
   localparam logic [IDW-1:0]  STIM_TARGET_ID = 12'h0A5;

   // Word view with srcaddr riding above the data
   typedef struct packed {
      logic [31:0] srcaddr;
      logic [31:0] data;
   } emesh_word_t;

   // Double view holding full 64-bit data
   typedef struct packed {
      logic [31:0] data_hi;
      logic [31:0] data_lo;
   } emesh_double_t;

   typedef union packed {
      emesh_word_t   word;
      emesh_double_t dbl;
   } emesh_payload_t;

   // Declared MSB first so write lands in bit 0
   typedef struct packed {
      emesh_payload_t payload;   // [103:40]
      logic [AW-1:0]  dstaddr;   // [39:8]
      logic [4:0]     ctrlmode;  // [7:3]
      logic [1:0]     datamode;  // [2:1]
      logic           write;     // [0]
   } emesh_packet_t;

endpackage

// File: src/emesh_stimulus.sv
// ##########################################################################
// Start-triggered stimulus: STIM_COUNT word writes to STIM_TARGET_ID
// A start seen while running or after done is ignored
// done stays high until reset
// ##########################################################################
`timescale 1ns/1ns

module emesh_stimulus (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    start,
   input  logic                    src_wait,
   output logic                    src_access,
   output emesh_pkg::emesh_packet_t src_packet,
   output logic                    done
);

   logic [emesh_pkg::STIM_IDX_W-1:0]        idx;       // Current packet index
   logic                                    active;    // Sequence running
   logic                                    xfer;      // Packet accepted
   logic                                    last;      // Final packet on the wire
   logic [emesh_pkg::AW-emesh_pkg::IDW-1:0] addr_lo;   // Offset inside the core

   assign xfer = active && !src_wait;
   assign last = (idx == emesh_pkg::STIM_IDX_W'(emesh_pkg::STIM_COUNT - 1));

   // ########################################################################
   // Sequencer
   // ########################################################################
   always_ff @(posedge clk) begin
      if (reset) begin
         idx    <= '0;
         active <= 1'b0;
         done   <= 1'b0;
      end else if (!active) begin
         if (start && !done) begin   // Packet 0 shows next cycle
            active <= 1'b1;
            idx    <= '0;
         end
      end else if (xfer) begin
         if (last) begin
            active <= 1'b0;
            done   <= 1'b1;           // Cycle after last transfer
         end else begin
            idx <= idx + 1'b1;
         end
      end
   end

   assign src_access = active;

   // Packet follows idx only, so it holds while waiting
   assign addr_lo = emesh_pkg::STIM_BASE[emesh_pkg::AW-emesh_pkg::IDW-1:0]
                  + (emesh_pkg::AW-emesh_pkg::IDW)'({idx, 2'b00});

   always_comb begin
      src_packet                      = '0;
      src_packet.write                = 1'b1;
      src_packet.datamode             = emesh_pkg::DM_WORD;
      src_packet.ctrlmode             = '0;              // Not used downstream
      src_packet.dstaddr              = {emesh_pkg::STIM_TARGET_ID, addr_lo};
      src_packet.payload.word.srcaddr = '0;              // No reply expected
      src_packet.payload.word.data    = emesh_pkg::STIM_DATA_SEED
                                      + 32'(idx) * emesh_pkg::STIM_DATA_STEP;
   end

   // Stalled packet must reappear unchanged next cycle
   a_stim_hold : assert property (@(posedge clk) disable iff (reset)
      src_access && src_wait |=> src_access && $stable(src_packet))
      else $error("stimulus packet changed under wait");

endmodule

// File: src/emesh_memory.sv
// ##########################################################################
// 64-bit memory model for one link, MAW byte address bits decoded
// Reads answer with a write to the request's srcaddr, one read in flight
// wait_out stays high while a reply is held, which stalls writes too
// Byte and half modes behave as words, storage has no reset
// ##########################################################################
`timescale 1ns/1ns

module emesh_memory (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [emesh_pkg::IDW-1:0]     coreid,
   input  logic                          access_in,
   input  emesh_pkg::emesh_packet_t      packet_in,
   input  logic                          rsp_wait,
   output logic                          wait_out,
   output logic                          rsp_access,
   output emesh_pkg::emesh_packet_t      rsp_packet
);

   logic [63:0]                  mem [0:emesh_pkg::MEM_DEPTH-1];
   logic [emesh_pkg::MAW-4:0]    index;      // Entry select
   logic                         hi_half;    // Upper word of the entry
   logic                         xfer;       // Incoming packet accepted
   logic                         read_xfer;
   logic                         rsp_valid;  // Reply pending
   logic [63:0]                  rd_entry;
   emesh_pkg::emesh_packet_t     rsp_q;      // Reply payload register

   assign index     = packet_in.dstaddr[emesh_pkg::MAW-1:3];
   assign hi_half   = packet_in.dstaddr[2];
   assign wait_out  = rsp_valid;             // Blocks while reply is out
   assign xfer      = access_in && !wait_out;
   assign read_xfer = xfer && !packet_in.write;
   assign rd_entry  = mem[index];

   // ########################################################################
   // Write path
   // ########################################################################
   always_ff @(posedge clk) begin
      if (xfer && packet_in.write) begin
         case (packet_in.datamode)
            emesh_pkg::DM_DOUBLE:
               mem[index] <= packet_in.payload.dbl;
            emesh_pkg::DM_BYTE,
            emesh_pkg::DM_HALF,
            emesh_pkg::DM_WORD: begin
               if (hi_half)
                  mem[index][63:32] <= packet_in.payload.word.data;
               else
                  mem[index][31:0]  <= packet_in.payload.word.data;
            end
            default: ;
         endcase
      end
   end

   // ########################################################################
   // Read reply
   // ########################################################################
   always_ff @(posedge clk) begin
      if (reset) begin
         rsp_valid <= 1'b0;
      end else if (read_xfer) begin
         rsp_valid <= 1'b1;
      end else if (rsp_valid && !rsp_wait) begin
         rsp_valid <= 1'b0;          // Reply taken by the mux
      end
   end

   // Request always carries srcaddr in the word view
   always_ff @(posedge clk) begin
      if (read_xfer) begin
         rsp_q          <= '0;
         rsp_q.write    <= 1'b1;
         rsp_q.datamode <= packet_in.datamode;
         rsp_q.ctrlmode <= packet_in.ctrlmode;        // Passed through
         rsp_q.dstaddr  <= packet_in.payload.word.srcaddr;
         if (packet_in.datamode == emesh_pkg::DM_DOUBLE) begin
            rsp_q.payload.dbl.data_hi <= rd_entry[63:32];
            rsp_q.payload.dbl.data_lo <= rd_entry[31:0];
         end else begin
            rsp_q.payload.word.srcaddr <=
               {coreid, (emesh_pkg::AW - emesh_pkg::IDW)'(0)};
            rsp_q.payload.word.data    <= hi_half ? rd_entry[63:32] : rd_entry[31:0];
         end
      end
   end

   assign rsp_access = rsp_valid;
   assign rsp_packet = rsp_q;

   // A second request must not overwrite a pending reply
   a_one_read : assert property (@(posedge clk) disable iff (reset)
      rsp_valid |=> !rsp_valid || $stable(rsp_q))
      else $error("memory reply overwritten while pending");

endmodule

// File: src/emesh_monitor.sv
// ##########################################################################
// Link monitor, counts device packets and those for another core
// A packet counts when dut_access is high and dut_stall is low
// Counters saturate at all ones
// ##########################################################################
`timescale 1ns/1ns

module emesh_monitor (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [emesh_pkg::IDW-1:0]     coreid,
   input  logic                          dut_access,
   input  emesh_pkg::emesh_packet_t      dut_packet,
   input  logic                          dut_stall,
   output logic [emesh_pkg::CNT_W-1:0]   rx_count,
   output logic [emesh_pkg::CNT_W-1:0]   misroute_count
);

   logic                      xfer;      // Device packet taken
   logic                      misroute;  // Destination is another core
   logic [emesh_pkg::IDW-1:0] dst_id;

   assign xfer     = dut_access && !dut_stall;
   assign dst_id   = dut_packet.dstaddr[emesh_pkg::AW-1 -: emesh_pkg::IDW];
   assign misroute = (dst_id != coreid);

   // ########################################################################
   // Counters
   // ########################################################################
   always_ff @(posedge clk) begin
      if (reset) begin
         rx_count <= '0;
      end else if (xfer && (rx_count != '1)) begin
         rx_count <= rx_count + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         misroute_count <= '0;
      end else if (xfer && misroute && (misroute_count != '1)) begin
         misroute_count <= misroute_count + 1'b1;   // Sticks at max
      end
   end

   // Device must not drop or alter a stalled packet
   a_dut_hold : assert property (@(posedge clk) disable iff (reset)
      dut_access && dut_stall |=> dut_access && $stable(dut_packet))
      else $error("device packet changed while stalled");

endmodule

// File: src/emesh_response_mux.sv
// ##########################################################################
// Fixed-priority merge onto the outgoing channel, stimulus first
// Purely combinational, the memory keeps its reply while held back
// clk and reset only clock the hold check
// ##########################################################################
`timescale 1ns/1ns

module emesh_response_mux (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      stim_src_access,
   input  emesh_pkg::emesh_packet_t  stim_src_packet,
   input  logic                      mem_rsp_access,
   input  emesh_pkg::emesh_packet_t  mem_rsp_packet,
   input  logic                      out_wait,
   output logic                      stim_src_wait,
   output logic                      mem_rsp_wait,
   output logic                      out_access,
   output emesh_pkg::emesh_packet_t  out_packet
);

   logic grant_stim;  // Stimulus owns the channel

   assign grant_stim    = stim_src_access;
   assign out_access    = stim_src_access || mem_rsp_access;
   assign out_packet    = grant_stim ? stim_src_packet : mem_rsp_packet;
   assign stim_src_wait = out_wait;                 // Only the link can stall it
   assign mem_rsp_wait  = grant_stim || out_wait;   // Loses to stimulus

   // Held reply stays put until it wins the channel
   a_mem_hold : assert property (@(posedge clk) disable iff (reset)
      mem_rsp_access && mem_rsp_wait |=> mem_rsp_access && $stable(mem_rsp_packet))
      else $error("memory reply changed while held back");

endmodule

// File: src/emesh_driver.sv
// ##########################################################################
// emesh traffic driver for one mesh link, packets as flat PW-bit words
// stim_wait stalls the device while a memory reply is pending
// Memory replies trail stimulus traffic on the outgoing channel
// ##########################################################################
`timescale 1ns/1ns

module emesh_driver (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          start,           // Kicks off stimulus
   input  logic [emesh_pkg::IDW-1:0]     coreid,          // This core's id
   input  logic                          dut_access,
   input  logic [emesh_pkg::PW-1:0]      dut_packet,
   input  logic                          dut_wait,
   output logic                          stim_access,
   output logic [emesh_pkg::PW-1:0]      stim_packet,
   output logic                          stim_wait,
   output logic                          stim_done,
   output logic [emesh_pkg::CNT_W-1:0]   rx_count,
   output logic [emesh_pkg::CNT_W-1:0]   misroute_count
);

   // Stimulus to mux
   logic                     stim_src_access;
   emesh_pkg::emesh_packet_t stim_src_packet;
   logic                     stim_src_wait;

   // Memory to mux
   logic                     mem_rsp_access;
   emesh_pkg::emesh_packet_t mem_rsp_packet;
   logic                     mem_rsp_wait;

   // ########################################################################
   // Blocks
   // ########################################################################
   emesh_stimulus stimulus (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .src_wait   (stim_src_wait),
      .src_access (stim_src_access),
      .src_packet (stim_src_packet),
      .done       (stim_done)
   );

   emesh_monitor monitor (
      .clk            (clk),
      .reset          (reset),
      .coreid         (coreid),
      .dut_access     (dut_access),
      .dut_packet     (dut_packet),
      .dut_stall      (stim_wait),    // Same transfer rule as memory
      .rx_count       (rx_count),
      .misroute_count (misroute_count)
   );

   emesh_memory memory (
      .clk        (clk),
      .reset      (reset),
      .coreid     (coreid),
      .access_in  (dut_access),
      .packet_in  (dut_packet),
      .rsp_wait   (mem_rsp_wait),
      .wait_out   (stim_wait),
      .rsp_access (mem_rsp_access),
      .rsp_packet (mem_rsp_packet)
   );

   emesh_response_mux response_mux (
      .clk             (clk),
      .reset           (reset),
      .stim_src_access (stim_src_access),
      .stim_src_packet (stim_src_packet),
      .mem_rsp_access  (mem_rsp_access),
      .mem_rsp_packet  (mem_rsp_packet),
      .out_wait        (dut_wait),
      .stim_src_wait   (stim_src_wait),
      .mem_rsp_wait    (mem_rsp_wait),
      .out_access      (stim_access),
      .out_packet      (stim_packet)
   );

endmodule

// File: verification/tb_emesh_driver.sv
// ##########################################################################
// Testbench for the single-link emesh driver, DUT instance uut
// Device side is modelled here, with random dut_wait about one cycle in four
// Shadow memory covers only entries written by this testbench
// Stimulus runs once per reset, so the run resets between phases
// ##########################################################################
`timescale 1ns/1ns

module tb_emesh_driver;

   localparam int          RESET_CYCLES = 16;
   localparam int          WAIT_LIMIT   = 400;     // Cycles allowed per wait loop
   localparam logic [11:0] MY_ID        = 12'h012; // Driven coreid
   localparam logic [11:0] OTHER_ID     = 12'h3C7; // Misrouted traffic
   localparam logic [11:0] REPLY_ID     = 12'h2B4; // Read replies head here

   logic                               clk = 1'b0;
   logic                               reset;
   logic                               start;
   logic [emesh_pkg::IDW-1:0]          coreid;
   logic                               dut_access;
   logic [emesh_pkg::PW-1:0]           dut_packet;
   logic                               dut_wait;
   logic                               stim_access;
   logic [emesh_pkg::PW-1:0]           stim_packet;
   logic                               stim_wait;
   logic                               stim_done;
   logic [emesh_pkg::CNT_W-1:0]        rx_count;
   logic [emesh_pkg::CNT_W-1:0]        misroute_count;

   integer                             seed;
   emesh_pkg::emesh_packet_t           stim_q [$];   // Expected stimulus, in order
   emesh_pkg::emesh_packet_t           rsp_q [$];    // Expected memory replies
   logic [63:0]                        shadow [0:emesh_pkg::MEM_DEPTH-1];
   logic [31:0]                        pool [0:13];  // Payload words drawn at time zero
   int                                 errors;
   int                                 checks;
   int                                 tests_run;
   int                                 tests_failed;
   int                                 stim_seen;
   int                                 dev_sent;
   int                                 dev_misroute;

   always #50 clk = ~clk;   // 100 ns period

   emesh_driver uut (
      .clk            (clk),
      .reset          (reset),
      .start          (start),
      .coreid         (coreid),
      .dut_access     (dut_access),
      .dut_packet     (dut_packet),
      .dut_wait       (dut_wait),
      .stim_access    (stim_access),
      .stim_packet    (stim_packet),
      .stim_wait      (stim_wait),
      .stim_done      (stim_done),
      .rx_count       (rx_count),
      .misroute_count (misroute_count)
   );

   // ########################################################################
   // Reference models
   // ########################################################################
   function automatic emesh_pkg::emesh_packet_t stim_expected(input int i);
      emesh_pkg::emesh_packet_t p;
      p                      = '0;
      p.write                = 1'b1;
      p.datamode             = emesh_pkg::DM_WORD;
      p.dstaddr              = {emesh_pkg::STIM_TARGET_ID, 20'h0}
                             + emesh_pkg::STIM_BASE + 32'(4 * i);
      p.payload.word.data    = emesh_pkg::STIM_DATA_SEED + 32'(i) * 32'h0101_0101;
      return p;                                  // srcaddr stays zero
   endfunction

   // Reply to a read built from the shadow entry
   function automatic emesh_pkg::emesh_packet_t reply_expected(
      input emesh_pkg::emesh_packet_t req,
      input logic [63:0]              entry
   );
      emesh_pkg::emesh_packet_t p;
      p          = '0;
      p.write    = 1'b1;
      p.datamode = req.datamode;
      p.ctrlmode = req.ctrlmode;
      p.dstaddr  = req.payload.word.srcaddr;     // Back to the requester
      if (req.datamode == emesh_pkg::DM_DOUBLE) begin
         p.payload.dbl.data_hi = entry[63:32];
         p.payload.dbl.data_lo = entry[31:0];
      end else begin
         p.payload.word.srcaddr = {coreid, 20'h0};
         p.payload.word.data    = req.dstaddr[2] ? entry[63:32] : entry[31:0];
      end
      return p;
   endfunction

   function automatic emesh_pkg::emesh_packet_t make_packet(
      input logic        wr,
      input logic [1:0]  dm,
      input logic [31:0] dst,
      input logic [63:0] payload
   );
      emesh_pkg::emesh_packet_t p;
      p          = '0;
      p.write    = wr;
      p.datamode = dm;
      p.dstaddr  = dst;
      p.payload  = payload;
      return p;
   endfunction

   // ########################################################################
   // Helpers
   // ########################################################################
   task automatic abort_on_timeout(input string what);
      $display("TIMEOUT at %0t: %s", $time, what);
      $display("RESULT: FAIL");
      $finish;
   endtask

   task automatic compare(input string name, input logic [103:0] got,
                          input logic [103:0] want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("FAIL t=%0t %s: got %0h expected %0h", $time, name, got, want);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests_run++;
      if (errors == errs_before) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - errs_before);
      end
   endtask

   // Called and returns at a falling edge
   task automatic apply_reset;
      reset      = 1'b1;
      start      = 1'b0;
      dut_access = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      reset      = 1'b0;
      stim_q.delete();
      rsp_q.delete();
      stim_seen    = 0;
      dev_sent     = 0;
      dev_misroute = 0;
   endtask

   // Drives at the current falling edge and holds under stim_wait
   task automatic send_dev(input emesh_pkg::emesh_packet_t p);
      int                      cnt;
      logic [emesh_pkg::MAW-4:0] idx;
      cnt        = 0;
      idx        = p.dstaddr[emesh_pkg::MAW-1:3];
      dut_access = 1'b1;
      dut_packet = p;
      while (stim_wait && cnt < WAIT_LIMIT) begin
         @(negedge clk);
         cnt++;
      end
      if (stim_wait) begin
         abort_on_timeout("device packet held by stim_wait too long");
      end else begin
         dev_sent++;                              // Transfers at next rising edge
         if (p.dstaddr[31:20] != coreid)
            dev_misroute++;
         if (p.write && p.datamode == emesh_pkg::DM_DOUBLE)
            shadow[idx] = p.payload;
         else if (p.write && p.dstaddr[2])
            shadow[idx][63:32] = p.payload.word.data;
         else if (p.write)
            shadow[idx][31:0] = p.payload.word.data;  // Byte and half too
         else
            rsp_q.push_back(reply_expected(p, shadow[idx]));
         @(negedge clk);
      end
   endtask

   task automatic go_idle;
      dut_access = 1'b0;
   endtask

   task automatic await_done;
      int cnt;
      cnt = 0;
      while (!stim_done && cnt < WAIT_LIMIT) begin
         @(negedge clk);
         cnt++;
      end
      if (!stim_done)
         abort_on_timeout("stim_done never rose");
   endtask

   task automatic drain_replies;
      int cnt;
      cnt = 0;
      while (rsp_q.size() != 0 && cnt < WAIT_LIMIT) begin
         @(negedge clk);
         cnt++;
      end
      if (rsp_q.size() != 0)
         abort_on_timeout("expected memory replies never arrived");
   endtask

   // ########################################################################
   // Outgoing channel checker and link back-pressure
   // ########################################################################
   always @(posedge clk) begin : check_outgoing
      emesh_pkg::emesh_packet_t got;
      emesh_pkg::emesh_packet_t want;
      if (!reset && stim_access && !dut_wait) begin
         got = stim_packet;
         if (got.dstaddr[31:20] == emesh_pkg::STIM_TARGET_ID) begin
            stim_seen++;
            if (stim_q.size() == 0) begin
               errors++;
               $display("ERROR at %0t: stimulus packet sent with none expected", $time);
            end else begin
               want = stim_q.pop_front();
               compare("stim_packet", got, want);
            end
         end else if (rsp_q.size() == 0) begin
            errors++;
            $display("ERROR at %0t: memory reply sent with no read pending", $time);
         end else begin
            want = rsp_q.pop_front();
            compare("stim_packet", got, want);
         end
      end
   end

   // Drawn every falling edge, ignored by the checker during reset
   always @(negedge clk) begin
      dut_wait = (($random(seed) & 3) == 0);   // About one in four
   end

   // ########################################################################
   // Test sequence
   // ########################################################################
   initial begin
      int          e0;
      logic [31:0] a;
      logic [31:0] src;
      logic [63:0] d;
      seed         = 99466;
      for (int n = 0; n < 14; n++)
         pool[n] = $random(seed);
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      coreid       = MY_ID;
      dut_packet   = '0;
      dut_wait     = 1'b0;
      apply_reset();

      e0 = errors;
      compare("stim_access", stim_access, 0);
      compare("stim_wait", stim_wait, 0);
      compare("stim_done", stim_done, 0);
      compare("rx_count", rx_count, 0);
      compare("misroute_count", misroute_count, 0);
      report_test("reset state", e0);

      // Both halves of four entries with the last one through another coreid
      e0 = errors;
      for (int k = 0; k < 4; k++) begin
         a = {(k == 3) ? OTHER_ID : MY_ID, 20'h00100 + 20'(k * 8)};
         send_dev(make_packet(1'b1, emesh_pkg::DM_WORD, a, {32'h0, pool[2 * k]}));
         send_dev(make_packet(1'b1, emesh_pkg::DM_WORD, a + 4, {32'h0, pool[2 * k + 1]}));
      end
      for (int k = 0; k < 4; k++) begin
         a   = {MY_ID, 20'h00100 + 20'(k * 8)};
         src = {REPLY_ID, 20'h00400 + 20'(k * 16)};
         send_dev(make_packet(1'b0, emesh_pkg::DM_WORD, a + 4, {src, 32'h0}));
         send_dev(make_packet(1'b0, emesh_pkg::DM_WORD, a, {src + 8, 32'h0}));
      end
      go_idle();
      drain_replies();
      report_test("word write and read", e0);

      e0 = errors;
      for (int k = 0; k < 3; k++) begin
         a = {MY_ID, 20'h00200 + 20'(k * 8)};
         d = {pool[8 + 2 * k], pool[9 + 2 * k]};
         send_dev(make_packet(1'b1, emesh_pkg::DM_DOUBLE, a, d));
      end
      for (int k = 0; k < 3; k++) begin
         a   = {MY_ID, 20'h00200 + 20'(k * 8)};
         src = {REPLY_ID, 20'h00800 + 20'(k * 16)};
         send_dev(make_packet(1'b0, emesh_pkg::DM_DOUBLE, a, {src, 32'h0}));
         send_dev(make_packet(1'b0, emesh_pkg::DM_WORD, a + 4, {src + 4, 32'h0}));
      end
      go_idle();
      drain_replies();
      report_test("double write and read", e0);

      e0 = errors;
      @(negedge clk);                             // Counters lag one cycle
      compare("rx_count", rx_count, dev_sent);
      compare("misroute_count", misroute_count, dev_misroute);
      report_test("monitor counters", e0);

      // Stimulus alone
      apply_reset();
      e0 = errors;
      for (int i = 0; i < emesh_pkg::STIM_COUNT; i++)
         stim_q.push_back(stim_expected(i));
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      await_done();
      @(negedge clk);
      compare("stimulus packets seen", stim_seen, emesh_pkg::STIM_COUNT);
      compare("stim_done", stim_done, 1);
      compare("stim_access", stim_access, 0);
      report_test("stimulus sequence", e0);

      // Reads racing a second stimulus run
      apply_reset();
      e0 = errors;
      for (int i = 0; i < emesh_pkg::STIM_COUNT; i++)
         stim_q.push_back(stim_expected(i));
      fork
         begin
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            await_done();
         end
         begin
            for (int k = 0; k < 4; k++) begin
               a   = {(k == 1) ? OTHER_ID : MY_ID, 20'h00100 + 20'(k * 8)};
               src = {REPLY_ID, 20'h00C00 + 20'(k * 16)};
               send_dev(make_packet(1'b0, emesh_pkg::DM_WORD, a + 20'(4 * (k % 2)),
                                    {src, 32'h0}));
               a   = {MY_ID, 20'h00200 + 20'((k % 3) * 8)};
               send_dev(make_packet(1'b0, emesh_pkg::DM_DOUBLE, a, {src + 8, 32'h0}));
            end
            go_idle();
         end
      join
      drain_replies();
      compare("stimulus packets seen", stim_seen, emesh_pkg::STIM_COUNT);
      report_test("reads during stimulus", e0);

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0 && tests_failed == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// File: sim.f
src/emesh_pkg.sv
src/emesh_stimulus.sv
src/emesh_memory.sv
src/emesh_monitor.sv
src/emesh_response_mux.sv
src/emesh_driver.sv
verification/tb_emesh_driver.sv

// File: Bender.yml
package:
  name: emesh_driver

sources:
  - src/emesh_pkg.sv
  - src/emesh_stimulus.sv
  - src/emesh_memory.sv
  - src/emesh_monitor.sv
  - src/emesh_response_mux.sv
  - src/emesh_driver.sv
  - target: test
    files:
      - verification/tb_emesh_driver.sv
